//--- link_clk_pkg.sv
/*
 shared types and register map for the link clock/reset sequencer
 imported by wildcard in the module headers that need it
*/
package link_clk_pkg;

   //##############################
   // sequencer states
   //##############################

   // encoding is also the STATUS state field
   typedef enum logic [2:0]
   {
      RESET_ALL  = 3'd0,  // everything held in reset
      START_PLL  = 3'd1,  // plls out of reset, waiting for cclk lock
      STOP_PLL   = 3'd2,  // quiet time, plls back in reset
      START_CHIP = 3'd3,  // chip reset released, plls still held
      HOLD_LOCK  = 3'd4,  // plls running, wait for both locks
      ACTIVE     = 3'd5   // link logic released
   } seq_state_t;

   //##############################
   // register port types
   //##############################

   typedef logic [1:0] reg_addr_t;   // host register address
   typedef logic [7:0] reg_data_t;   // host register data
   typedef logic [7:0] act_count_t;  // link activation count

   // register map
   localparam reg_addr_t ADDR_CTRL   = 2'd0;
   localparam reg_addr_t ADDR_STATUS = 2'd1;
   localparam reg_addr_t ADDR_COUNT  = 2'd2;

   // CTRL bits
   localparam int CTRL_LINK_EN    = 0;  // read/write
   localparam int CTRL_SOFT_RESET = 1;  // write one, self clearing

   // STATUS bits, state sits in [2:0]
   localparam int STAT_CCLK_LOCK = 3;
   localparam int STAT_LCLK_LOCK = 4;

endpackage

//--- seq_ctrl_if.sv
/*
 control and status between the register block and the sequencer
 regs side drives enable and soft reset, seq side drives state and activate
*/
`timescale 1ns/1ps

interface seq_ctrl_if import link_clk_pkg::*; ();

   logic       link_en;     // link enable, level
   logic       soft_reset;  // one cycle restart request
   seq_state_t state;       // current sequencer state
   logic       activate;    // one cycle pulse on entry to ACTIVE

   // register block side
   modport regs
   (
      output link_en,
      output soft_reset,
      input  state,
      input  activate
   );

   // sequencer side
   modport seq
   (
      input  link_en,
      input  soft_reset,
      output state,
      output activate
   );

endinterface

//--- lock_sync.sv
/*
 brings the two asynchronous pll lock inputs into sys_clk
 two flop sync, then lock only counts after LOCK_FILTER steady high cycles
*/
`timescale 1ns/1ps

module lock_sync #(
   parameter int unsigned LOCK_FILTER = 8  // steady high cycles before lock counts
) (
   input  logic sys_clk,
   input  logic reset_in,
   input  logic cclk_locked_raw,  // async from core clock pll
   input  logic lclk_locked_raw,  // async from link clock pll
   output logic cclk_lock,
   output logic lclk_lock
);

   localparam int unsigned CNT_W = $clog2(LOCK_FILTER + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(LOCK_FILTER);

   logic [1:0]       raw_lock;          // [0] cclk, [1] lclk
   logic [1:0]       meta_q;            // first sync stage
   logic [1:0]       sync_q;            // second sync stage
   logic [CNT_W-1:0] high_cnt [0:1];    // consecutive high cycles

   assign raw_lock = {lclk_locked_raw, cclk_locked_raw};

   //##############################
   // synchronizer
   //##############################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         meta_q <= '0;
         sync_q <= '0;
      end
      else
      begin
         meta_q <= raw_lock;
         sync_q <= meta_q;
      end
   end

   //##############################
   // chatter filter
   //##############################

   // saturating run length of synchronized high, cleared by any low
   always_ff @(posedge sys_clk)
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (reset_in || !sync_q[i])
            high_cnt[i] <= '0;
         else if (high_cnt[i] != CNT_MAX)
            high_cnt[i] <= high_cnt[i] + 1'b1;  // still counting up
      end
   end

   // drop is immediate, rise waits for the full run
   assign cclk_lock = sync_q[0] && (high_cnt[0] == CNT_MAX);
   assign lclk_lock = sync_q[1] && (high_cnt[1] == CNT_MAX);

endmodule

//--- reset_sequencer.sv
/*
 bring-up sequencer for the chip link, steps only on the heartbeat tick
 drives pll reset, chip reset (active low) and link reset from its state
*/
`timescale 1ns/1ps

module reset_sequencer import link_clk_pkg::*; #(
   parameter int unsigned HB_WIDTH = 4  // tick every 2**HB_WIDTH cycles
) (
   input  logic   sys_clk,
   input  logic   reset_in,
   seq_ctrl_if.seq ctrl,
   input  logic   cclk_lock,    // filtered core clock lock
   input  logic   lclk_lock,    // filtered link clock lock
   output logic   pll_reset,    // to both plls
   output logic   chip_resetb,  // to the chip, low is reset
   output logic   link_reset    // to the link logic
);

   logic [HB_WIDTH-1:0] hb_cnt;      // free running
   logic                hb_tick;     // one cycle per wrap
   logic                seq_reset;   // any source of restart
   logic                both_lock;
   logic                activate_q;
   seq_state_t          state;
   seq_state_t          state_next;

   //##############################
   // heartbeat
   //##############################

   // only the hard reset touches the heartbeat
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         hb_cnt  <= '0;
         hb_tick <= 1'b0;
      end
      else
      begin
         hb_cnt  <= hb_cnt + 1'b1;
         hb_tick <= &hb_cnt;  // high for one cycle after the all-ones count
      end
   end

   //##############################
   // state machine
   //##############################

   assign seq_reset = reset_in || !ctrl.link_en || ctrl.soft_reset;
   assign both_lock = cclk_lock && lclk_lock;

   always_comb
   begin
      state_next = state;  // hold between ticks
      if (hb_tick)
      begin
         case (state)
            RESET_ALL:
               state_next = START_PLL;
            START_PLL:
               if (cclk_lock)
                  state_next = STOP_PLL;  // core pll is good, go quiet
            STOP_PLL:
               state_next = START_CHIP;
            START_CHIP:
               state_next = HOLD_LOCK;
            HOLD_LOCK:
               if (both_lock)
                  state_next = ACTIVE;
            ACTIVE:
               if (!both_lock)
                  state_next = RESET_ALL;  // lost lock, start over
            default:
               state_next = RESET_ALL;
         endcase
      end
   end

   // restart wins over the heartbeat
   always_ff @(posedge sys_clk)
   begin
      if (seq_reset)
      begin
         state      <= RESET_ALL;
         activate_q <= 1'b0;
      end
      else
      begin
         state      <= state_next;
         activate_q <= (state_next == ACTIVE) && (state != ACTIVE);  // entry only
      end
   end

   assign ctrl.state    = state;
   assign ctrl.activate = activate_q;

   //##############################
   // reset decode
   //##############################

   // plls held in reset during the quiet time around the chip reset edge
   assign pll_reset   = state inside {RESET_ALL, STOP_PLL, START_CHIP};
   assign chip_resetb = state inside {START_CHIP, HOLD_LOCK, ACTIVE};
   assign link_reset  = (state != ACTIVE);

endmodule

//--- link_cfg_regs.sv
/*
 host register block with valid/ready request and response channels
 holds link enable, issues soft reset, reports state, locks and activations
*/
`timescale 1ns/1ps

module link_cfg_regs import link_clk_pkg::*; (
   input  logic      sys_clk,
   input  logic      reset_in,
   seq_ctrl_if.regs  ctrl,
   input  logic      cclk_lock,
   input  logic      lclk_lock,
   // request channel
   input  logic      req_valid,
   output logic      req_ready,
   input  logic      req_write,
   input  reg_addr_t req_addr,
   input  reg_data_t req_wdata,
   // response channel
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output reg_data_t rsp_rdata
);

   logic       accept;      // request handshake this cycle
   logic       wr_ctrl;     // accepted write to CTRL
   logic       link_en_q;
   logic       soft_reset_q;
   reg_data_t  rd_data;     // read mux output
   act_count_t act_count;

   // one outstanding request, blocked while a response waits
   assign req_ready = !rsp_valid;
   assign accept    = req_valid && req_ready;
   assign wr_ctrl   = accept && req_write && (req_addr == ADDR_CTRL);

   //##############################
   // read mux
   //##############################

   always_comb
   begin
      rd_data = '0;  // unknown address reads zero
      case (req_addr)
         ADDR_CTRL:
            rd_data[CTRL_LINK_EN] = link_en_q;  // soft reset reads as zero
         ADDR_STATUS:
         begin
            rd_data[2:0]            = ctrl.state;
            rd_data[STAT_CCLK_LOCK] = cclk_lock;
            rd_data[STAT_LCLK_LOCK] = lclk_lock;
         end
         ADDR_COUNT:
            rd_data = act_count;
         default:
            rd_data = '0;
      endcase
   end

   //##############################
   // control and response
   //##############################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         link_en_q    <= 1'b0;
         soft_reset_q <= 1'b0;
         rsp_valid    <= 1'b0;
      end
      else
      begin
         if (wr_ctrl)
            link_en_q <= req_wdata[CTRL_LINK_EN];
         soft_reset_q <= wr_ctrl && req_wdata[CTRL_SOFT_RESET];  // single cycle pulse
         if (accept)
            rsp_valid <= 1'b1;
         else if (rsp_ready)
            rsp_valid <= 1'b0;  // response taken
      end
   end

   // data captured at acceptance, held while the response waits
   always_ff @(posedge sys_clk)
   begin
      if (accept)
         rsp_rdata <= req_write ? '0 : rd_data;
   end

   // activation count, saturates at all ones
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
         act_count <= '0;
      else if (ctrl.activate && (act_count != '1))
         act_count <= act_count + 1'b1;
   end

   assign ctrl.link_en    = link_en_q;
   assign ctrl.soft_reset = soft_reset_q;

endmodule

//--- link_clk_top.sv
/*
 link clock/reset sequencer top, plain ports for host and pll locks
 ties lock filter, sequencer and register block together
*/
`timescale 1ns/1ps

module link_clk_top import link_clk_pkg::*; #(
   parameter int unsigned HB_WIDTH    = 4,  // heartbeat counter width
   parameter int unsigned LOCK_FILTER = 8   // lock filter length in cycles
) (
   input  logic      sys_clk,
   input  logic      reset_in,
   input  logic      cclk_locked_raw,  // async pll lock
   input  logic      lclk_locked_raw,  // async pll lock
   // host register port
   input  logic      req_valid,
   output logic      req_ready,
   input  logic      req_write,
   input  reg_addr_t req_addr,
   input  reg_data_t req_wdata,
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output reg_data_t rsp_rdata,
   // reset outputs
   output logic      pll_reset,
   output logic      chip_resetb,
   output logic      link_reset
);

   logic cclk_lock;  // filtered, sys_clk domain
   logic lclk_lock;

   seq_ctrl_if ctrl_if ();

   lock_sync #(
      .LOCK_FILTER     (LOCK_FILTER)
   ) u_lock_sync (
      .sys_clk         (sys_clk),
      .reset_in        (reset_in),
      .cclk_locked_raw (cclk_locked_raw),
      .lclk_locked_raw (lclk_locked_raw),
      .cclk_lock       (cclk_lock),
      .lclk_lock       (lclk_lock)
   );

   reset_sequencer #(
      .HB_WIDTH    (HB_WIDTH)
   ) u_reset_sequencer (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .ctrl        (ctrl_if.seq),
      .cclk_lock   (cclk_lock),
      .lclk_lock   (lclk_lock),
      .pll_reset   (pll_reset),
      .chip_resetb (chip_resetb),
      .link_reset  (link_reset)
   );

   link_cfg_regs u_link_cfg_regs (
      .sys_clk   (sys_clk),
      .reset_in  (reset_in),
      .ctrl      (ctrl_if.regs),
      .cclk_lock (cclk_lock),
      .lclk_lock (lclk_lock),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata)
   );

endmodule

//--- tb_link_clk_assertions.sv
/*
 concurrent checks on the reset outputs and the host handshake
 bound into link_clk_top from the testbench
*/
`timescale 1ns/1ps

module tb_link_clk_assertions (
   input logic       sys_clk,
   input logic       reset_in,
   input logic       pll_reset,
   input logic       chip_resetb,
   input logic       link_reset,
   input logic       req_ready,
   input logic       rsp_valid,
   input logic       rsp_ready,
   input logic [7:0] rsp_rdata
);

   //##############################
   // reset outputs
   //##############################

   // hard reset puts everything back in reset next cycle
   reset_outputs: assert property (@(posedge sys_clk)
      reset_in |=> pll_reset && !chip_resetb && link_reset)
      else $error("reset outputs not in reset after reset_in");

   link_needs_chip: assert property (@(posedge sys_clk) disable iff (reset_in)
      !link_reset |-> chip_resetb && !pll_reset)  // link only with chip and plls running
      else $error("link released while chip or pll still in reset");

   //##############################
   // host handshake
   //##############################

   rsp_held: assert property (@(posedge sys_clk) disable iff (reset_in)
      rsp_valid && !rsp_ready |=> rsp_valid)
      else $error("rsp_valid dropped before rsp_ready");

   rsp_data_held: assert property (@(posedge sys_clk) disable iff (reset_in)
      rsp_valid && !rsp_ready |=> $stable(rsp_rdata))  // data frozen while waiting
      else $error("rsp_rdata changed while response pending");

   one_outstanding: assert property (@(posedge sys_clk) disable iff (reset_in)
      rsp_valid |-> !req_ready)
      else $error("req_ready high while response pending");

endmodule

//--- tb_link_clk.sv
/*
 directed testbench for the link clock/reset sequencer
 plays the plls by driving the raw locks and polls STATUS over the host port
*/
`timescale 1ns/1ps

module tb_link_clk import link_clk_pkg::*; ();

   localparam int HB_WIDTH       = 4;
   localparam int LOCK_FILTER    = 8;
   localparam int HB_CYCLES      = 1 << HB_WIDTH;  // cycles per heartbeat
   localparam int CLK_PERIOD     = 40;
   localparam int TEST_TICKS     = 40;   // sum of heartbeat bounds in the tests
   localparam int TIMEOUT_CYCLES = TEST_TICKS * HB_CYCLES + 600;  // plus host traffic

   logic      sys_clk;
   logic      reset_in;
   logic      cclk_locked_raw;
   logic      lclk_locked_raw;
   logic      req_valid;
   logic      req_ready;
   logic      req_write;
   reg_addr_t req_addr;
   reg_data_t req_wdata;
   logic      rsp_valid;
   logic      rsp_ready;
   reg_data_t rsp_rdata;
   logic      pll_reset;
   logic      chip_resetb;
   logic      link_reset;

   int         cycle  = 0;
   int         errors = 0;
   int         checks = 0;
   logic [7:0] lfsr;        // stall generator state
   logic       snap_pll;    // outputs seen in the acceptance cycle
   logic       snap_chipb;
   logic       snap_link;

   link_clk_top #(
      .HB_WIDTH    (HB_WIDTH),
      .LOCK_FILTER (LOCK_FILTER)
   ) DUT (.*);

   bind link_clk_top tb_link_clk_assertions u_assertions (
      .sys_clk     (sys_clk),
      .reset_in    (reset_in),
      .pll_reset   (pll_reset),
      .chip_resetb (chip_resetb),
      .link_reset  (link_reset),
      .req_ready   (req_ready),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp_rdata   (rsp_rdata)
   );

   //##############################
   // clock, cycle count, watchdog
   //##############################

   initial
   begin
      sys_clk = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
   end

   always @(posedge sys_clk)
      cycle <= cycle + 1;  // time base for the heartbeat bounds

   initial
   begin
      #(CLK_PERIOD * TIMEOUT_CYCLES);
      $display("watchdog timeout, run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

   //##############################
   // helpers
   //##############################

   // fibonacci lfsr x^8+x^6+x^5+x^4+1 stepped once per bit
   function automatic logic [7:0] lfsr_bits(input int n);
      logic [7:0] val;
      logic       fb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
         lfsr = {lfsr[6:0], fb};
         val  = {val[6:0], fb};
      end
      return val;
   endfunction

   // bring-up order with ACTIVE wrapping to RESET_ALL on lock loss
   function automatic seq_state_t next_state(input seq_state_t st);
      case (st)
         RESET_ALL:  return START_PLL;
         START_PLL:  return STOP_PLL;
         STOP_PLL:   return START_CHIP;
         START_CHIP: return HOLD_LOCK;
         HOLD_LOCK:  return ACTIVE;
         default:    return RESET_ALL;
      endcase
   endfunction

   task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("%s at %0t", msg, $time);
   endtask

   // one request with the response held back for stall cycles
   task automatic host_access(input logic write, input reg_addr_t addr,
                              input reg_data_t wdata, input int stall,
                              output reg_data_t rdata);
      @(negedge sys_clk);
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      req_wdata = wdata;
      while (!req_ready)
         @(negedge sys_clk);
      snap_pll   = pll_reset;  // same cycle as the sampled read data
      snap_chipb = chip_resetb;
      snap_link  = link_reset;
      @(negedge sys_clk);
      req_valid = 1'b0;
      repeat (stall)
      begin
         check_eq("req_ready", 8'(req_ready), 8'h00);  // back-pressure
         @(negedge sys_clk);
      end
      check_eq("rsp_valid", 8'(rsp_valid), 8'h01);
      rsp_ready = 1'b1;
      rdata     = rsp_rdata;
      @(negedge sys_clk);
      rsp_ready = 1'b0;
      check_eq("rsp_valid", 8'(rsp_valid), 8'h00);
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t wdata);
      reg_data_t rdata;
      host_access(1'b1, addr, wdata, 0, rdata);
      check_eq("write rsp_rdata", rdata, 8'h00);
   endtask

   task automatic read_reg(input reg_addr_t addr, input int stall, output reg_data_t rdata);
      host_access(1'b0, addr, 8'h00, stall, rdata);
   endtask

   // reset outputs expected for a state
   task automatic check_decode(input seq_state_t st);
      logic exp_pll;
      logic exp_chipb;
      logic exp_link;
      exp_pll   = (st == RESET_ALL) || (st == STOP_PLL) || (st == START_CHIP);
      exp_chipb = (st == START_CHIP) || (st == HOLD_LOCK) || (st == ACTIVE);
      exp_link  = (st != ACTIVE);
      check_eq("pll_reset", 8'(snap_pll), 8'(exp_pll));
      check_eq("chip_resetb", 8'(snap_chipb), 8'(exp_chipb));
      check_eq("link_reset", 8'(snap_link), 8'(exp_link));
   endtask

   // poll STATUS until target is reached in order within n_ticks
   task automatic wait_for_state(input seq_state_t target, input seq_state_t start,
                                 input int n_ticks);
      reg_data_t  data;
      seq_state_t prev;
      seq_state_t st;
      int         deadline;
      prev     = start;
      st       = start;
      deadline = cycle + n_ticks * HB_CYCLES;
      while ((st != target) && (cycle < deadline))
      begin
         read_reg(ADDR_STATUS, 0, data);
         st = seq_state_t'(data[2:0]);
         if ((st != prev) && (st != next_state(prev)))
            report_error($sformatf("state went from %0d to %0d out of order", prev, st));
         check_decode(st);
         prev = st;
      end
      if (st != target)
         report_error($sformatf("state %0d not reached in %0d heartbeats", target, n_ticks));
   endtask

   //##############################
   // directed tests
   //##############################

   task automatic after_reset_defaults();
      reg_data_t data;
      check_eq("pll_reset", 8'(pll_reset), 8'h01);
      check_eq("chip_resetb", 8'(chip_resetb), 8'h00);
      check_eq("link_reset", 8'(link_reset), 8'h01);
      read_reg(ADDR_STATUS, 0, data);
      check_eq("STATUS", data, 8'(RESET_ALL));  // locks low too
      read_reg(ADDR_COUNT, 0, data);
      check_eq("COUNT", data, 8'h00);
      read_reg(ADDR_CTRL, 0, data);
      check_eq("CTRL", data, 8'h00);
   endtask

   task automatic stuck_lock_hold();
      reg_data_t  data;
      seq_state_t st;
      int         deadline;
      lclk_locked_raw = 1'b1;  // link pll locks but core pll never does
      write_reg(ADDR_CTRL, 8'h01);
      deadline = cycle + 6 * HB_CYCLES;
      while (cycle < deadline)
      begin
         read_reg(ADDR_STATUS, 0, data);
         st = seq_state_t'(data[2:0]);
         if (!(st inside {RESET_ALL, START_PLL}))
            report_error($sformatf("state %0d passed START_PLL without core lock", st));
         check_eq("link_reset", 8'(snap_link), 8'h01);
         check_eq("STATUS cclk lock", 8'(data[STAT_CCLK_LOCK]), 8'h00);
      end
      read_reg(ADDR_STATUS, 0, data);
      check_eq("STATUS lclk lock", 8'(data[STAT_LCLK_LOCK]), 8'h01);  // filter long done
   endtask

   task automatic full_bring_up();
      reg_data_t data;
      write_reg(ADDR_CTRL, 8'h00);  // known start in RESET_ALL
      write_reg(ADDR_CTRL, 8'h01);
      cclk_locked_raw = 1'b1;
      lclk_locked_raw = 1'b1;
      wait_for_state(ACTIVE, RESET_ALL, 8);
      read_reg(ADDR_COUNT, 0, data);
      check_eq("COUNT", data, 8'h01);
   endtask

   task automatic lock_loss_restart();
      reg_data_t data;
      lclk_locked_raw = 1'b0;  // link pll drops out
      wait_for_state(RESET_ALL, ACTIVE, 2);
      check_eq("link_reset", 8'(link_reset), 8'h01);
      lclk_locked_raw = 1'b1;
      wait_for_state(ACTIVE, RESET_ALL, 8);
      read_reg(ADDR_COUNT, 0, data);
      check_eq("COUNT", data, 8'h02);
   endtask

   task automatic disable_and_soft_reset();
      reg_data_t data;
      write_reg(ADDR_CTRL, 8'h00);
      check_eq("chip_resetb", 8'(chip_resetb), 8'h00);
      read_reg(ADDR_STATUS, 0, data);
      check_eq("STATUS state", 8'(data[2:0]), 8'(RESET_ALL));
      read_reg(ADDR_CTRL, 0, data);
      check_eq("CTRL", data, 8'h00);
      write_reg(ADDR_CTRL, 8'h01);
      wait_for_state(ACTIVE, RESET_ALL, 8);
      write_reg(ADDR_CTRL, 8'h03);  // enable kept with soft reset pulse
      check_eq("chip_resetb", 8'(chip_resetb), 8'h00);
      check_eq("link_reset", 8'(link_reset), 8'h01);
      read_reg(ADDR_CTRL, 0, data);
      check_eq("CTRL", data, 8'h01);  // soft reset bit reads zero
      wait_for_state(ACTIVE, RESET_ALL, 8);
      read_reg(ADDR_COUNT, 0, data);
      check_eq("COUNT", data, 8'h04);
   endtask

   task automatic read_back_pressure();
      reg_addr_t addr;
      reg_data_t data;
      reg_data_t exp;
      int        stall;
      for (int i = 0; i < 12; i++)
      begin
         addr  = reg_addr_t'(lfsr_bits(2));
         stall = int'(lfsr_bits(3));
         case (addr)
            ADDR_CTRL:   exp = 8'h01;
            ADDR_STATUS: exp = {3'b000, 1'b1, 1'b1, ACTIVE};  // both locks up in ACTIVE
            ADDR_COUNT:  exp = 8'h04;
            default:     exp = 8'h00;
         endcase
         read_reg(addr, stall, data);
         check_eq("rsp_rdata", data, exp);
      end
   endtask

   //##############################
   // main sequence
   //##############################

   initial
   begin
      reset_in        = 1'b1;
      cclk_locked_raw = 1'b0;
      lclk_locked_raw = 1'b0;
      req_valid       = 1'b0;
      req_write       = 1'b0;
      req_addr        = '0;
      req_wdata       = '0;
      rsp_ready       = 1'b0;
      lfsr            = 8'd36;
      repeat (3) @(negedge sys_clk);
      reset_in = 1'b0;
      after_reset_defaults();
      stuck_lock_hold();
      full_bring_up();
      lock_loss_restart();
      disable_and_soft_reset();
      read_back_pressure();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- vlog.f
link_clk_pkg.sv
seq_ctrl_if.sv
lock_sync.sv
reset_sequencer.sv
link_cfg_regs.sv
link_clk_top.sv
tb_link_clk_assertions.sv
tb_link_clk.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_link_clk -o tb_link_clk
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/tb_link_clk > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation did not pass, see $LOG"
   exit 1
fi
